//--- rtl/ooo_defines.svh
////////////////////////////////////////////////////////////
// sizes and instruction word layout of the out-of-order core
// include in any file that needs a width or a field slice
////////////////////////////////////////////////////////////
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// datapath and structure sizes
`define XLEN      32
`define ARCH_REGS 8
`define ROB_DEPTH 8
`define RS_DEPTH  4

// instruction fields, opcode in the top nibble
`define OPC_MSB 31
`define OPC_LSB 28
`define RD_MSB  27
`define RD_LSB  25
`define RS1_MSB 24
`define RS1_LSB 22
`define RS2_MSB 21
`define RS2_LSB 19
// immediate, sign extended by the consumer
`define IMM_MSB 15
`define IMM_LSB 0

`endif

//--- rtl/ooo_pkg.sv
////////////////////////////////////////////////////////////
// types shared by the fetch, rename, issue and retire blocks
// import into every module that passes these between blocks
////////////////////////////////////////////////////////////
`include "ooo_defines.svh"

package ooo_pkg;

	// opcode encoding in the top four bits of the word
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SLL  = 4'h5,
		OP_ADDI = 4'h6,
		OP_HALT = 4'h7
	} opcode_e;

	typedef logic [$clog2(`ARCH_REGS)-1:0] reg_idx_t;
	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

	// source operand, tag names the producer while not ready
	typedef struct packed {
		logic [`XLEN-1:0] value;
		rob_tag_t         tag;
		logic             ready;
	} operand_t;

	// decoded instruction held in the dispatch register
	typedef struct packed {
		logic                       valid;
		opcode_e                    op;
		reg_idx_t                   rd;
		reg_idx_t                   rs1;
		reg_idx_t                   rs2;
		logic [`IMM_MSB-`IMM_LSB:0] imm;
		logic                       use_imm;
	} dispatch_t;

	// map table view of both sources
	typedef struct packed {
		rob_tag_t tag_a;
		logic     busy_a;
		rob_tag_t tag_b;
		logic     busy_b;
	} rename_t;

	// RS to ALU
	typedef struct packed {
		logic             valid;
		opcode_e          op;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		rob_tag_t         tag;
	} issue_t;

	// common data bus
	typedef struct packed {
		logic             valid;
		rob_tag_t         tag;
		logic [`XLEN-1:0] value;
	} cdb_t;

	// retirement record, valid travels beside it
	typedef struct packed {
		reg_idx_t         rd;
		logic [`XLEN-1:0] value;
	} commit_t;

endpackage

//--- rtl/fetch_decode.sv
////////////////////////////////////////////////////////////
// instruction fetch over a Wishbone classic master port
// decodes each word into the dispatch register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ooo_defines.svh"

module fetch_decode import ooo_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  logic             dispatch_fire,
	input  logic             halted,
	output logic             wb_cyc,
	output logic             wb_stb,
	output logic [`XLEN-1:0] wb_adr,
	input  logic [`XLEN-1:0] wb_dat_i,
	input  logic             wb_ack,
	output dispatch_t        dispatch
);

	// word address of the next fetch
	logic [`XLEN-1:0] pc;
	logic             halt_seen;
	logic             start;
	dispatch_t        decoded;

	//////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////

	always_comb begin
		decoded.valid   = 1'b1;
		decoded.op      = opcode_e'(wb_dat_i[`OPC_MSB:`OPC_LSB]);
		decoded.rd      = wb_dat_i[`RD_MSB:`RD_LSB];
		decoded.rs1     = wb_dat_i[`RS1_MSB:`RS1_LSB];
		decoded.rs2     = wb_dat_i[`RS2_MSB:`RS2_LSB];
		decoded.imm     = wb_dat_i[`IMM_MSB:`IMM_LSB];
		decoded.use_imm = (decoded.op == OP_ADDI);
		// second source comes from the immediate
		if (decoded.op == OP_ADDI) begin
			decoded.rs2 = '0;
		end
		// halt reads and writes nothing
		if (decoded.op == OP_HALT) begin
			decoded.rd  = '0;
			decoded.rs1 = '0;
			decoded.rs2 = '0;
		end
	end

	//////////////////////////////////////////////////////////////
	// bus cycle
	//////////////////////////////////////////////////////////////

	// one request in flight and only once the dispatch register frees
	assign start  = !wb_cyc && !halt_seen && !halted && (!dispatch.valid || dispatch_fire);
	assign wb_adr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_cyc    <= 1'b0;
			wb_stb    <= 1'b0;
			pc        <= '0;
			halt_seen <= 1'b0;
		end else if (start) begin
			wb_cyc <= 1'b1;
			wb_stb <= 1'b1;
		end else if (wb_cyc && wb_ack) begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			pc     <= pc + 1'b1;
			// nothing past a halt is fetched
			if (decoded.op == OP_HALT) begin
				halt_seen <= 1'b1;
			end
		end
	end

	// dispatch register loaded at ack and emptied on dispatch
	always_ff @(posedge clock) begin
		if (reset) begin
			dispatch <= '0;
		end else if (wb_cyc && wb_ack) begin
			dispatch <= decoded;
		end else if (dispatch_fire) begin
			dispatch.valid <= 1'b0;
		end
	end

	assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_cyc);

endmodule

//--- rtl/map_table.sv
////////////////////////////////////////////////////////////
// rename table, newest ROB tag and busy bit per register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ooo_defines.svh"

module map_table import ooo_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      dispatch_fire,
	input  dispatch_t dispatch,
	input  rob_tag_t  alloc_tag,
	input  logic      retire_valid,
	input  reg_idx_t  retire_rd,
	input  rob_tag_t  retire_tag,
	output rename_t   rename
);

	rob_tag_t              tags [`ARCH_REGS];
	logic [`ARCH_REGS-1:0] busy;
	logic                  claim;

	// r0 is never renamed
	assign claim = dispatch_fire && (dispatch.rd != '0);

	// lookup for the instruction in the dispatch register
	always_comb begin
		rename.tag_a  = tags[dispatch.rs1];
		rename.busy_a = busy[dispatch.rs1];
		rename.tag_b  = tags[dispatch.rs2];
		rename.busy_b = busy[dispatch.rs2];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			// clear only if no younger writer took the register
			if (retire_valid && busy[retire_rd] && (tags[retire_rd] == retire_tag)) begin
				busy[retire_rd] <= 1'b0;
			end
			// a new claim wins over a same cycle retire
			if (claim) begin
				busy[dispatch.rd] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (claim) begin
			tags[dispatch.rd] <= alloc_tag;
		end
	end

endmodule

//--- rtl/reservation_station.sv
////////////////////////////////////////////////////////////
// reservation station, captures operands from the CDB
// and issues the oldest ready entry to the ALU
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reservation_station import ooo_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      dispatch_fire,
	input  dispatch_t dispatch,
	input  rob_tag_t  alloc_tag,
	input  operand_t  src_a,
	input  operand_t  src_b,
	input  cdb_t      cdb,
	output issue_t    issue,
	output logic      rs_full
);

	localparam int IDX_W = $clog2(`RS_DEPTH);

	typedef struct packed {
		opcode_e  op;
		operand_t a;
		operand_t b;
		rob_tag_t tag;
	} rs_entry_t;

	logic [`RS_DEPTH-1:0] valid;
	rs_entry_t            entry [`RS_DEPTH];
	// count of younger valid entries, largest is oldest
	logic [IDX_W-1:0]     age [`RS_DEPTH];
	logic                 write_en;
	logic [IDX_W-1:0]     free_idx;
	logic                 issue_en;
	logic [IDX_W-1:0]     issue_idx;

	assign rs_full = &valid;
	// halt needs no ALU slot
	assign write_en = dispatch_fire && (dispatch.op != OP_HALT);

	// lowest free slot
	always_comb begin
		free_idx = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_idx = IDX_W'(i);
			end
		end
	end

	// oldest entry with both operands in hand
	always_comb begin
		issue_en  = 1'b0;
		issue_idx = '0;
		for (int i = 0; i < `RS_DEPTH; i++) begin
			if (valid[i] && entry[i].a.ready && entry[i].b.ready &&
				(!issue_en || (age[i] > age[issue_idx]))) begin
				issue_en  = 1'b1;
				issue_idx = IDX_W'(i);
			end
		end
	end

	always_comb begin
		issue.valid = issue_en;
		issue.op    = entry[issue_idx].op;
		issue.a     = entry[issue_idx].a.value;
		issue.b     = entry[issue_idx].b.value;
		issue.tag   = entry[issue_idx].tag;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else begin
			if (issue_en) begin
				valid[issue_idx] <= 1'b0;
			end
			if (write_en) begin
				valid[free_idx] <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// entry write, age and wakeup
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			if (write_en && (IDX_W'(i) == free_idx)) begin
				entry[i].op  <= dispatch.op;
				entry[i].a   <= src_a;
				entry[i].b   <= src_b;
				entry[i].tag <= alloc_tag;
				age[i]       <= '0;
			end else begin
				// new arrival is younger, a leaving younger entry is gone
				age[i] <= age[i] + IDX_W'(write_en && valid[i])
					- IDX_W'(issue_en && (age[i] > age[issue_idx]));
				if (cdb.valid && !entry[i].a.ready && (entry[i].a.tag == cdb.tag)) begin
					entry[i].a.value <= cdb.value;
					entry[i].a.ready <= 1'b1;
				end
				if (cdb.valid && !entry[i].b.ready && (entry[i].b.tag == cdb.tag)) begin
					entry[i].b.value <= cdb.value;
					entry[i].b.ready <= 1'b1;
				end
			end
		end
	end

	// core must hold dispatch while the station is full
	assert property (@(posedge clock) disable iff (reset) write_en |-> !rs_full);

endmodule

//--- rtl/cdb_alu.sv
////////////////////////////////////////////////////////////
// integer ALU, result broadcast on the CDB one cycle later
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ooo_defines.svh"

module cdb_alu import ooo_pkg::*; (
	input  logic   clock,
	input  logic   reset,
	input  issue_t issue,
	output cdb_t   cdb
);

	logic [`XLEN-1:0] result;

	always_comb begin
		case (issue.op)
			// addi arrives with the immediate in b
			OP_ADD, OP_ADDI: result = issue.a + issue.b;
			OP_SUB:          result = issue.a - issue.b;
			OP_AND:          result = issue.a & issue.b;
			OP_OR:           result = issue.a | issue.b;
			OP_XOR:          result = issue.a ^ issue.b;
			// shift amount from the low bits only
			OP_SLL:          result = issue.a << issue.b[$clog2(`XLEN)-1:0];
			default:         result = '0;
		endcase
	end

	// broadcast register
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb.valid <= 1'b0;
		end else begin
			cdb.valid <= issue.valid;
		end
		cdb.tag   <= issue.tag;
		cdb.value <= result;
	end

endmodule

//--- rtl/reorder_buffer.sv
////////////////////////////////////////////////////////////
// reorder buffer, allocates tags at dispatch, completes
// from the CDB and retires in program order
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reorder_buffer import ooo_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      dispatch_fire,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	input  rob_tag_t  lookup_a,
	input  rob_tag_t  lookup_b,
	output operand_t  lookup_a_val,
	output operand_t  lookup_b_val,
	output rob_tag_t  alloc_tag,
	output logic      rob_full,
	output logic      commit_valid,
	output commit_t   commit,
	output rob_tag_t  retire_tag,
	output logic      halted
);

	localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

	rob_tag_t              head;
	rob_tag_t              tail;
	logic [CNT_W-1:0]      count;
	logic [`ROB_DEPTH-1:0] done;
	logic [`ROB_DEPTH-1:0] is_halt;
	reg_idx_t              rd_q [`ROB_DEPTH];
	logic [`XLEN-1:0]      value_q [`ROB_DEPTH];
	logic                  retire;
	rob_tag_t              cdb_offset;

	assign alloc_tag = tail;
	assign rob_full  = (count == CNT_W'(`ROB_DEPTH));

	// head leaves once done, nothing after halt
	assign retire       = (count != '0) && done[head] && !halted;
	assign commit_valid = retire && !is_halt[head];
	assign commit.rd    = rd_q[head];
	assign commit.value = value_q[head];
	assign retire_tag   = head;

	// forwarding of finished results to dispatch
	assign lookup_a_val = '{value: value_q[lookup_a], tag: lookup_a, ready: done[lookup_a]};
	assign lookup_b_val = '{value: value_q[lookup_b], tag: lookup_b, ready: done[lookup_b]};

	always_ff @(posedge clock) begin
		if (reset) begin
			head   <= '0;
			tail   <= '0;
			count  <= '0;
			done   <= '0;
			halted <= 1'b0;
		end else begin
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;
			end
			// halt is complete as soon as it is allocated
			if (dispatch_fire) begin
				done[tail] <= (dispatch.op == OP_HALT);
				tail       <= tail + 1'b1;
			end
			if (retire) begin
				head <= head + 1'b1;
				if (is_halt[head]) begin
					halted <= 1'b1;
				end
			end
			count <= count + CNT_W'(dispatch_fire) - CNT_W'(retire);
		end
	end

	always_ff @(posedge clock) begin
		if (dispatch_fire) begin
			rd_q[tail]    <= dispatch.rd;
			is_halt[tail] <= (dispatch.op == OP_HALT);
		end
		if (cdb.valid) begin
			value_q[cdb.tag] <= cdb.value;
		end
	end

	// broadcast tag must sit between head and tail and not be done yet
	assign cdb_offset = cdb.tag - head;
	assert property (@(posedge clock) disable iff (reset)
		cdb.valid |-> (CNT_W'(cdb_offset) < count) && !done[cdb.tag]);

endmodule

//--- rtl/regfile.sv
////////////////////////////////////////////////////////////
// architectural registers, written only at retire
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ooo_defines.svh"

module regfile import ooo_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  reg_idx_t         rd_a,
	input  reg_idx_t         rd_b,
	output logic [`XLEN-1:0] val_a,
	output logic [`XLEN-1:0] val_b,
	input  logic             wr_en,
	input  reg_idx_t         wr_idx,
	input  logic [`XLEN-1:0] wr_data
);

	logic [`XLEN-1:0] regs [`ARCH_REGS];

	// r0 hardwired to zero
	assign val_a = (rd_a == '0) ? '0 : regs[rd_a];
	assign val_b = (rd_b == '0) ? '0 : regs[rd_b];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARCH_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

//--- rtl/ooo_core.sv
////////////////////////////////////////////////////////////
// top of the out-of-order core, Wishbone fetch in,
// commit stream and halt out
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core import ooo_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	output logic             wb_cyc,
	output logic             wb_stb,
	output logic [`XLEN-1:0] wb_adr,
	input  logic [`XLEN-1:0] wb_dat_i,
	input  logic             wb_ack,
	output logic             commit_valid,
	output commit_t          commit,
	output logic             halted
);

	localparam int IMM_W = `IMM_MSB - `IMM_LSB + 1;

	dispatch_t        dispatch;
	rename_t          rename;
	operand_t         src_a, src_b;
	operand_t         lookup_a_val, lookup_b_val;
	issue_t           issue;
	cdb_t             cdb;
	rob_tag_t         alloc_tag, retire_tag;
	logic [`XLEN-1:0] rf_a, rf_b;
	logic             dispatch_fire, rob_full, rs_full;

	assign dispatch_fire = dispatch.valid && !rob_full && !rs_full;

	// regfile if not renamed, else a finished ROB entry, else this cycle's CDB
	function automatic operand_t resolve(input logic busy, input rob_tag_t tag,
		input logic [`XLEN-1:0] rf_val, input operand_t rob_val, input cdb_t bus);
		operand_t res;
		res = '{value: rf_val, tag: tag, ready: 1'b1};
		if (busy) begin
			if (rob_val.ready) begin
				res.value = rob_val.value;
			end else if (bus.valid && (bus.tag == tag)) begin
				res.value = bus.value;
			end else begin
				res.value = '0;
				res.ready = 1'b0;
			end
		end
		return res;
	endfunction

	always_comb begin
		src_a = resolve(rename.busy_a, rename.tag_a, rf_a, lookup_a_val, cdb);
		src_b = resolve(rename.busy_b, rename.tag_b, rf_b, lookup_b_val, cdb);
		// sign extended immediate replaces the second source
		if (dispatch.use_imm) begin
			src_b.value = {{(`XLEN - IMM_W){dispatch.imm[IMM_W-1]}}, dispatch.imm};
			src_b.ready = 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////////////////

	fetch_decode u_fetch (.clock, .reset, .dispatch_fire, .halted, .wb_cyc, .wb_stb,
		.wb_adr, .wb_dat_i, .wb_ack, .dispatch);

	map_table u_map (.clock, .reset, .dispatch_fire, .dispatch, .alloc_tag,
		.retire_valid(commit_valid), .retire_rd(commit.rd), .retire_tag, .rename);

	regfile u_rf (.clock, .reset, .rd_a(dispatch.rs1), .rd_b(dispatch.rs2),
		.val_a(rf_a), .val_b(rf_b), .wr_en(commit_valid), .wr_idx(commit.rd),
		.wr_data(commit.value));

	reservation_station u_rs (.clock, .reset, .dispatch_fire, .dispatch, .alloc_tag,
		.src_a, .src_b, .cdb, .issue, .rs_full);

	cdb_alu u_alu (.clock, .reset, .issue, .cdb);

	reorder_buffer u_rob (.clock, .reset, .dispatch_fire, .dispatch, .cdb,
		.lookup_a(rename.tag_a), .lookup_b(rename.tag_b), .lookup_a_val,
		.lookup_b_val, .alloc_tag, .rob_full, .commit_valid, .commit, .retire_tag,
		.halted);

endmodule

//--- tests/tb_clock.sv
////////////////////////////////////////////////////////////
// free running testbench clock, 10 ns period
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock (
	output logic clock
);

	// low for the first half period
	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

endmodule

//--- tests/ooo_core_tb.sv
////////////////////////////////////////////////////////////
// testbench of the out-of-order core that runs the programs
// of the pattern file and checks each commit against them
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core_tb import ooo_pkg::*; ();

	localparam int          MEM_WORDS = 64;
	localparam logic [31:0] LFSR_SEED = 32'h3ec4_e9cc;

	logic             clock;
	logic             reset = 1'b1;
	logic             wb_cyc;
	logic             wb_stb;
	logic [`XLEN-1:0] wb_adr;
	logic [`XLEN-1:0] wb_dat_i = '0;
	logic             wb_ack = 1'b0;
	logic             commit_valid;
	commit_t          commit;
	logic             halted;

	// pattern file contents with per test offsets into the flat queues
	string            test_name [$];
	int               instr_base [$];
	int               instr_count [$];
	int               commit_base [$];
	int               commit_count [$];
	logic [`XLEN-1:0] instr_words [$];
	commit_t          exp_commit [$];

	// instruction memory behind the Wishbone slave
	logic [`XLEN-1:0] mem [MEM_WORDS];
	logic [31:0]      lfsr_state = LFSR_SEED;
	logic             ack_pending = 1'b0;
	logic [1:0]       ack_wait = '0;

	// test currently running
	string            cur_name = "";
	int               cur_base = 0;
	int               cur_count = 0;
	int               commit_seen = 0;
	int               cycle_count = 0;
	int               cycle_limit = 64;

	tb_clock u_clock (.clock);

	ooo_core dut (.clock, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_dat_i, .wb_ack,
		.commit_valid, .commit, .halted);

	//////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	task automatic next_delay(output logic [1:0] d);
		lfsr_state = lfsr_step(lfsr_state);
		d[1] = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		d[0] = lfsr_state[0];
	endtask

	// halt opcode with the whole address folded into the low bits
	function automatic logic [`XLEN-1:0] fill_word(input logic [`XLEN-1:0] adr);
		return {OP_HALT, adr[27:0] ^ {24'h0, adr[31:28]}};
	endfunction

	function automatic logic [`XLEN-1:0] read_word(input logic [`XLEN-1:0] adr);
		return (adr < MEM_WORDS) ? mem[adr] : fill_word(adr);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_commit(input string name, input commit_t expected,
		input commit_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: expected rd %0d value %h, actual rd %0d value %h",
				name, expected.rd, expected.value, actual.rd, actual.value));
		end
	endtask

	task automatic check_halt(input string name, input logic actual, input int seen,
		input int total);
		if (actual !== 1'b1) begin
			abort_run($sformatf("CHECK FAILED %s: expected halted 1, actual %b", name, actual));
		end
		if (seen != total) begin
			abort_run($sformatf("%s halted after %0d of %0d expected commits", name, seen, total));
		end
	endtask

	// reads T, I, C and E lines and skips # lines
	task automatic load_patterns();
		int          fd;
		int          n;
		int          rd_v;
		string       line;
		string       tag;
		string       name;
		logic [31:0] word;
		logic [31:0] value;
		fd = $fopen("tests/ooo_patterns.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the pattern file tests/ooo_patterns.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			tag = "";
			n = $fgets(line, fd);
			if (n > 0) begin
				n = $sscanf(line, "%s", tag);
			end
			if (tag == "T") begin
				n = $sscanf(line, "%s %s", tag, name);
				test_name.push_back(name);
				instr_base.push_back(instr_words.size());
				commit_base.push_back(exp_commit.size());
			end else if (tag == "I") begin
				n = $sscanf(line, "%s %h", tag, word);
				instr_words.push_back(word);
			end else if (tag == "C") begin
				n = $sscanf(line, "%s %h %h", tag, rd_v, value);
				exp_commit.push_back(commit_t'{rd: reg_idx_t'(rd_v), value: value});
			end else if (tag == "E") begin
				instr_count.push_back(instr_words.size() - instr_base[$]);
				commit_count.push_back(exp_commit.size() - commit_base[$]);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int t);
		@(posedge clock);
		reset <= 1'b1;
		@(posedge clock);
		// program and expectations swap while the core sits in reset
		cur_name = test_name[t];
		cur_base = commit_base[t];
		cur_count = commit_count[t];
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = fill_word(a);
		end
		for (int i = 0; i < instr_count[t]; i++) begin
			mem[i] = instr_words[instr_base[t] + i];
		end
		@(posedge clock);
		reset <= 1'b0;
		// commits checked by the monitor meanwhile
		while (halted !== 1'b1) begin
			@(posedge clock);
		end
		// quiet period so a stray commit past halt reaches the monitor
		repeat (4) @(posedge clock);
		check_halt(cur_name, halted, commit_seen, cur_count);
	endtask

	//////////////////////////////////////////////////////////////
	// Wishbone slave, commit monitor, timeout
	//////////////////////////////////////////////////////////////

	always @(posedge clock) begin : wb_slave
		logic [1:0] delay;
		if (reset) begin
			wb_ack      <= 1'b0;
			ack_pending <= 1'b0;
		end else begin
			wb_ack <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack) begin
				if (!ack_pending) begin
					// new request waits 0 to 3 cycles
					next_delay(delay);
					if (delay == 2'd0) begin
						wb_ack   <= 1'b1;
						wb_dat_i <= read_word(wb_adr);
					end else begin
						ack_pending <= 1'b1;
						ack_wait    <= delay - 2'd1;
					end
				end else if (ack_wait == 2'd0) begin
					wb_ack      <= 1'b1;
					wb_dat_i    <= read_word(wb_adr);
					ack_pending <= 1'b0;
				end else begin
					ack_wait <= ack_wait - 2'd1;
				end
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			commit_seen <= 0;
		end else if (commit_valid) begin
			if (commit_seen >= cur_count) begin
				abort_run($sformatf("%s committed r%0d beyond its expected commits",
					cur_name, commit.rd));
			end else begin
				check_commit(cur_name, exp_commit[cur_base + commit_seen], commit);
			end
			commit_seen <= commit_seen + 1;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			abort_run($sformatf("run did not finish within %0d cycles, stuck in %s",
				cycle_limit, cur_name));
		end
	end

	initial begin
		load_patterns();
		// generous budget per instruction of the whole file
		cycle_limit = 64 + 40 * instr_words.size();
		for (int t = 0; t < test_name.size(); t++) begin
			run_test(t);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

//--- build.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/fetch_decode.sv
rtl/map_table.sv
rtl/reservation_station.sv
rtl/cdb_alu.sv
rtl/reorder_buffer.sv
rtl/regfile.sv
rtl/ooo_core.sv
tests/tb_clock.sv
tests/ooo_core_tb.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ooo_pkg.sv
      - rtl/fetch_decode.sv
      - rtl/map_table.sv
      - rtl/reservation_station.sv
      - rtl/cdb_alu.sv
      - rtl/reorder_buffer.sv
      - rtl/regfile.sv
      - rtl/ooo_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clock.sv
      - tests/ooo_core_tb.sv

//--- tests/ooo_patterns.txt
# T test name | I instruction word hex | C expected commit: rd hex, value hex
# E ends the test, # lines are comments
T alu_ops
I 62001234
I 6400fff0
I 06500000
I 18500000
I 2a500000
I 3c500000
I 4e500000
I 56500000
I 70000000
C 1 00001234
C 2 fffffff0
C 3 00001224
C 4 00001244
C 5 00001230
C 6 fffffff4
C 7 ffffedc4
C 3 12340000
E
T dep_chain
I 62000001
I 04480000
I 06900000
I 08d80000
I 1b080000
I 6d400100
I 70000000
C 1 00000001
C 2 00000002
C 3 00000004
C 4 00000008
C 5 00000007
C 6 00000107
E
T waw_order
I 62000005
I 62400003
I 62000020
I 04480000
I 70000000
C 1 00000005
C 1 00000008
C 1 00000020
C 2 00000040
E
T rob_fill
I 62000011
I 64000022
I 66000033
I 68000044
I 6a000055
I 6c000066
I 6e000077
I 62008000
I 70000000
C 1 00000011
C 2 00000022
C 3 00000033
C 4 00000044
C 5 00000055
C 6 00000066
C 7 00000077
C 1 ffff8000
E
T r0_halt
I 60000055
I 02000000
I 70000000
I 66000009
C 0 00000055
C 1 00000000
E
